// ==== Makefile ====
# Verilator flow for the micro-op ALU

VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0
SIM_BIN   = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
rtl/alu_pkg.sv
rtl/alu_arith.sv
rtl/alu_logic.sv
rtl/alu_flags.sv
rtl/alu.sv
tb/tb_clock.sv
tb/alu_checker.sv
tb/alu_tb.sv

// ==== rtl/alu.sv ====
`default_nettype none

module alu import alu_pkg::*; (
  input  micro_op_e opcode,
  input  reg_t      s,
  input  reg_t      t,
  input  imm_t      imm,
  input  bit_mode_e bit_mode,
  input  reg_t      eflags_as_src,
  output reg_t      d,
  output reg_t      eflags
);

  logic        subtract;
  logic        use_cf;
  logic        use_imm;
  logic        use_logic;
  logic        write_d;
  logic        carry_in;
  logic_op_e   logic_op;
  flag_class_e flag_class;
  reg_t        imm_ext;
  reg_t        operand_b;
  reg_t        arith_sum;
  logic        arith_carry;
  logic        arith_overflow;
  reg_t        logic_result;
  reg_t        picked;

  always_comb begin
    subtract   = 1'b0;
    use_cf     = 1'b0;
    use_imm    = 1'b0;
    use_logic  = 1'b0;
    write_d    = 1'b1;
    logic_op   = LOGIC_MOV;
    flag_class = FLAGS_ARITH;
    case (opcode)
      MICRO_ADD, MICRO_ADDI: begin
        use_imm = (opcode == MICRO_ADDI);
      end
      MICRO_ADC, MICRO_ADCI: begin
        use_imm = (opcode == MICRO_ADCI);
        use_cf  = 1'b1;
      end
      MICRO_SUB, MICRO_SUBI: begin
        use_imm  = (opcode == MICRO_SUBI);
        subtract = 1'b1;
      end
      MICRO_SBB, MICRO_SBBI: begin
        use_imm  = (opcode == MICRO_SBBI);
        subtract = 1'b1;
        use_cf   = 1'b1;
      end
      MICRO_CMP, MICRO_CMPI: begin
        use_imm  = (opcode == MICRO_CMPI);
        subtract = 1'b1;
        write_d  = 1'b0; // Flags only
      end
      MICRO_AND, MICRO_ANDI, MICRO_TEST, MICRO_TESTI: begin
        use_imm    = (opcode == MICRO_ANDI) || (opcode == MICRO_TESTI);
        use_logic  = 1'b1;
        logic_op   = LOGIC_AND;
        flag_class = FLAGS_LOGIC;
        write_d    = (opcode == MICRO_AND) || (opcode == MICRO_ANDI);
      end
      MICRO_OR, MICRO_ORI: begin
        use_imm    = (opcode == MICRO_ORI);
        use_logic  = 1'b1;
        logic_op   = LOGIC_OR;
        flag_class = FLAGS_LOGIC;
      end
      MICRO_XOR, MICRO_XORI: begin
        use_imm    = (opcode == MICRO_XORI);
        use_logic  = 1'b1;
        logic_op   = LOGIC_XOR;
        flag_class = FLAGS_LOGIC;
      end
      MICRO_MOV, MICRO_MOVI: begin
        use_imm    = (opcode == MICRO_MOVI);
        use_logic  = 1'b1;
        flag_class = FLAGS_KEEP; // MOV leaves flags alone
      end
      MICRO_SLLI: begin
        use_imm    = 1'b1;
        use_logic  = 1'b1;
        logic_op   = LOGIC_SLL;
        flag_class = FLAGS_LOGIC;
      end
      default: begin
        write_d    = 1'b0;
        flag_class = FLAGS_CLEAR; // Undefined code gives all zero
      end
    endcase
  end

  assign imm_ext   = {{(REG_W-IMM_W){1'b0}}, imm};
  assign operand_b = use_imm ? imm_ext : t;
  assign carry_in  = use_cf & eflags_as_src[FLAG_CF];

  alu_arith arith (
    .a        (s),
    .b        (operand_b),
    .carry_in (carry_in),
    .subtract (subtract),
    .bit_mode (bit_mode),
    .sum      (arith_sum),
    .carry    (arith_carry),
    .overflow (arith_overflow)
  );

  alu_logic logic_unit (
    .a        (s),
    .b        (operand_b),
    .op       (logic_op),
    .bit_mode (bit_mode),
    .result   (logic_result)
  );

  assign picked = use_logic ? logic_result : arith_sum;

  alu_flags flags (
    .result        (picked),
    .carry         (arith_carry),
    .overflow      (arith_overflow),
    .flag_class    (flag_class),
    .bit_mode      (bit_mode),
    .eflags_as_src (eflags_as_src),
    .eflags        (eflags)
  );

  assign d = write_d ? picked : '0; // CMP and TEST keep only their flags

endmodule

`default_nettype wire

// ==== rtl/alu_arith.sv ====
`default_nettype none

module alu_arith import alu_pkg::*; (
  input  reg_t      a,
  input  reg_t      b,
  input  logic      carry_in,
  input  logic      subtract,
  input  bit_mode_e bit_mode,
  output reg_t      sum,
  output logic      carry,
  output logic      overflow
);

  reg_t           mask;
  reg_t           a_m;
  reg_t           b_m;
  logic [REG_W:0] cin_ext;
  logic [REG_W:0] wide;
  int             width;
  logic           sign_a;
  logic           sign_b;
  logic           sign_r;

  assign width   = mode_width(bit_mode);
  assign mask    = mode_mask(bit_mode);
  assign a_m     = a & mask; // Both operands cut to the mode width
  assign b_m     = b & mask;
  assign cin_ext = {{REG_W{1'b0}}, carry_in};

  always_comb begin
    if (subtract) begin
      wide = {1'b0, a_m} - {1'b0, b_m} - cin_ext;
    end else begin
      wide = {1'b0, a_m} + {1'b0, b_m} + cin_ext;
    end
  end

  assign sum = wide[REG_W-1:0] & mask;

  // With masked operands the bit just above the mode width holds the carry
  // out of an add, and a wrapped subtract leaves it set as the borrow
  assign carry = wide[width];

  assign sign_a = a_m[width-1];
  assign sign_b = b_m[width-1];
  assign sign_r = wide[width-1];

  always_comb begin
    if (subtract) begin
      overflow = (sign_a != sign_b) && (sign_r != sign_a); // Mixed signs may overflow
    end else begin
      overflow = (sign_a == sign_b) && (sign_r != sign_a); // Like signs may overflow
    end
  end

endmodule

`default_nettype wire

// ==== rtl/alu_flags.sv ====
`default_nettype none

module alu_flags import alu_pkg::*; (
  input  reg_t        result,
  input  logic        carry,
  input  logic        overflow,
  input  flag_class_e flag_class,
  input  bit_mode_e   bit_mode,
  input  reg_t        eflags_as_src,
  output reg_t        eflags
);

  reg_t masked;
  logic sign;
  logic zero;
  logic parity;

  assign masked = result & mode_mask(bit_mode);
  assign sign   = masked[mode_width(bit_mode)-1];
  assign zero   = (masked == '0);
  assign parity = ~(^masked); // Even count of ones over the mode width

  always_comb begin
    eflags = eflags_as_src;
    case (flag_class)
      FLAGS_ARITH: begin
        eflags[FLAG_CF] = carry;
        eflags[FLAG_PF] = parity;
        eflags[FLAG_AF] = 1'b0; // Auxiliary carry is not modelled
        eflags[FLAG_ZF] = zero;
        eflags[FLAG_SF] = sign;
        eflags[FLAG_OF] = overflow;
      end
      FLAGS_LOGIC: begin
        eflags[FLAG_CF] = 1'b0;
        eflags[FLAG_PF] = parity;
        eflags[FLAG_AF] = 1'b0;
        eflags[FLAG_ZF] = zero;
        eflags[FLAG_SF] = sign;
        eflags[FLAG_OF] = 1'b0;
      end
      FLAGS_KEEP: begin
        eflags = eflags_as_src;
      end
      default: begin
        eflags = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/alu_logic.sv ====
`default_nettype none

module alu_logic import alu_pkg::*; (
  input  reg_t      a,
  input  reg_t      b,
  input  logic_op_e op,
  input  bit_mode_e bit_mode,
  output reg_t      result
);

  reg_t raw;

  always_comb begin
    case (op)
      LOGIC_AND: raw = a & b;
      LOGIC_OR:  raw = a | b;
      LOGIC_XOR: raw = a ^ b;
      LOGIC_SLL: raw = a << b; // Whole count used, so large counts clear the word
      LOGIC_MOV: raw = b;
      default:   raw = '0;
    endcase
  end

  // Bits above the mode width come back as zero
  assign result = raw & mode_mask(bit_mode);

endmodule

`default_nettype wire

// ==== rtl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  localparam int REG_W = 64;
  localparam int IMM_W = 32;

  typedef logic [REG_W-1:0] reg_t;
  typedef logic [IMM_W-1:0] imm_t;

  // Code zero and everything above MICRO_SLLI are undefined
  typedef enum logic [5:0] {
    MICRO_ADD   = 6'd1,
    MICRO_ADDI  = 6'd2,
    MICRO_SUB   = 6'd3,
    MICRO_SUBI  = 6'd4,
    MICRO_ADC   = 6'd5,
    MICRO_ADCI  = 6'd6,
    MICRO_SBB   = 6'd7,
    MICRO_SBBI  = 6'd8,
    MICRO_CMP   = 6'd9,
    MICRO_CMPI  = 6'd10,
    MICRO_AND   = 6'd11,
    MICRO_ANDI  = 6'd12,
    MICRO_OR    = 6'd13,
    MICRO_ORI   = 6'd14,
    MICRO_XOR   = 6'd15,
    MICRO_XORI  = 6'd16,
    MICRO_TEST  = 6'd17,
    MICRO_TESTI = 6'd18,
    MICRO_MOV   = 6'd19,
    MICRO_MOVI  = 6'd20,
    MICRO_SLLI  = 6'd21
  } micro_op_e;

  typedef enum logic [1:0] {
    MODE_8  = 2'd0,
    MODE_16 = 2'd1,
    MODE_32 = 2'd2,
    MODE_64 = 2'd3
  } bit_mode_e;

  typedef enum logic [2:0] {
    LOGIC_AND = 3'd0,
    LOGIC_OR  = 3'd1,
    LOGIC_XOR = 3'd2,
    LOGIC_SLL = 3'd3,
    LOGIC_MOV = 3'd4
  } logic_op_e;

  typedef enum logic [1:0] {
    FLAGS_ARITH = 2'd0,
    FLAGS_LOGIC = 2'd1,
    FLAGS_KEEP  = 2'd2,
    FLAGS_CLEAR = 2'd3
  } flag_class_e;

  localparam int FLAG_CF = 0;
  localparam int FLAG_PF = 2;
  localparam int FLAG_AF = 4;
  localparam int FLAG_ZF = 6;
  localparam int FLAG_SF = 7;
  localparam int FLAG_OF = 11;

  function automatic int mode_width(bit_mode_e mode);
    case (mode)
      MODE_8:  return 8;
      MODE_16: return 16;
      MODE_32: return 32;
      default: return REG_W;
    endcase
  endfunction

  // Ones over the low mode_width bits
  function automatic reg_t mode_mask(bit_mode_e mode);
    return {REG_W{1'b1}} >> (REG_W - mode_width(mode));
  endfunction

endpackage

`default_nettype wire

// ==== tb/alu_checker.sv ====
`default_nettype none

module alu_checker import alu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  micro_op_e opcode,
  input  reg_t      s,
  input  reg_t      t,
  input  imm_t      imm,
  input  bit_mode_e bit_mode,
  input  reg_t      eflags_as_src,
  input  reg_t      d,
  input  reg_t      eflags,
  output int        error_count,
  output int        check_count
);

  logic [127:0] expected;

  function automatic int width_of(bit_mode_e mode);
    case (mode)
      MODE_8:  return 8;
      MODE_16: return 16;
      MODE_32: return 32;
      default: return 64;
    endcase
  endfunction

  // Two's complement value of the low w bits in a width that holds any sum
  function automatic logic signed [67:0] signed_value(reg_t value, int w);
    logic signed [67:0] r;
    r = {4'b0, value};
    if (value[w-1]) r = r - (68'sd1 <<< w);
    return r;
  endfunction

  function automatic logic even_parity(reg_t value, int w);
    int ones;
    ones = 0;
    for (int i = 0; i < w; i++) ones += int'(value[i]);
    return (ones % 2) == 0;
  endfunction

  // Returns {d, eflags} as the instruction set defines them
  function automatic logic [127:0] expected_outputs(micro_op_e op, reg_t s_in, reg_t t_in,
                                                    imm_t imm_in, bit_mode_e mode, reg_t fin);
    int                 w;
    reg_t               mask;
    reg_t               a;
    reg_t               b_full;
    reg_t               b;
    reg_t               res;
    reg_t               fl;
    logic               cin;
    logic               cf;
    logic               of;
    logic               arith;
    logic               write_d;
    logic signed [67:0] carry_s;
    logic signed [67:0] ideal;
    w = width_of(mode);
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    a = s_in & mask;
    b_full = op inside {MICRO_ADDI, MICRO_SUBI, MICRO_ADCI, MICRO_SBBI, MICRO_CMPI,
                        MICRO_ANDI, MICRO_ORI, MICRO_XORI, MICRO_TESTI, MICRO_MOVI,
                        MICRO_SLLI} ? {32'b0, imm_in} : t_in;
    b = b_full & mask;
    cin = (op inside {MICRO_ADC, MICRO_ADCI, MICRO_SBB, MICRO_SBBI}) ? fin[FLAG_CF] : 1'b0;
    carry_s = cin ? 68'sd1 : 68'sd0;
    arith = 1'b1;
    write_d = !(op inside {MICRO_CMP, MICRO_CMPI, MICRO_TEST, MICRO_TESTI});
    cf = 1'b0;
    of = 1'b0;
    case (op)
      MICRO_ADD, MICRO_ADDI, MICRO_ADC, MICRO_ADCI: begin
        res = (a + b + 64'(cin)) & mask;
        cf = ({1'b0, a} + {1'b0, b} + 65'(cin)) > {1'b0, mask}; // Unsigned sum too big
        ideal = signed_value(a, w) + signed_value(b, w) + carry_s;
        of = signed_value(res, w) != ideal;
      end
      MICRO_SUB, MICRO_SUBI, MICRO_SBB, MICRO_SBBI, MICRO_CMP, MICRO_CMPI: begin
        res = (a - b - 64'(cin)) & mask;
        cf = {1'b0, a} < ({1'b0, b} + 65'(cin)); // Borrow
        ideal = signed_value(a, w) - signed_value(b, w) - carry_s;
        of = signed_value(res, w) != ideal;
      end
      MICRO_AND, MICRO_ANDI, MICRO_TEST, MICRO_TESTI: begin
        res = a & b;
        arith = 1'b0;
      end
      MICRO_OR, MICRO_ORI: begin
        res = a | b;
        arith = 1'b0;
      end
      MICRO_XOR, MICRO_XORI: begin
        res = a ^ b;
        arith = 1'b0;
      end
      MICRO_SLLI: begin
        res = (b_full >= 64'(w)) ? '0 : ((a << b_full[5:0]) & mask);
        arith = 1'b0;
      end
      MICRO_MOV, MICRO_MOVI: begin
        return {b, fin}; // Flags untouched
      end
      default: begin
        return '0;
      end
    endcase
    fl = fin;
    fl[FLAG_CF] = arith ? cf : 1'b0;
    fl[FLAG_PF] = even_parity(res, w);
    fl[FLAG_AF] = 1'b0;
    fl[FLAG_ZF] = (res == '0);
    fl[FLAG_SF] = res[w-1];
    fl[FLAG_OF] = arith ? of : 1'b0;
    return {write_d ? res : 64'd0, fl};
  endfunction

  always_comb expected = expected_outputs(opcode, s, t, imm, bit_mode, eflags_as_src);

  always_ff @(posedge clk) begin
    if (reset) begin
      error_count <= 0;
      check_count <= 0;
    end else begin
      check_count <= check_count + 1;
      if ({d, eflags} !== expected) begin
        error_count <= error_count + 1;
        $write("Mismatch at time %0t: opcode %0d mode %0d s %h t %h imm %h flags in %h",
               $time, opcode, bit_mode, s, t, imm, eflags_as_src);
        $display(", got d %h eflags %h, expected d %h eflags %h",
                 d, eflags, expected[127:64], expected[63:0]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/alu_tb.sv ====
`default_nettype none

module alu_tb import alu_pkg::*; ();

  localparam int   RANDOM_CYCLES = 400;
  localparam int   DRAIN_LIMIT   = 10;
  localparam int   WATCHDOG_TIME = 40 * (RANDOM_CYCLES + 200);
  localparam reg_t SRC_FLAGS     = 64'hc3a5_0f0f_5a5a_f0d5; // CF set and noise in the other bits

  logic        clk;
  logic        reset;
  micro_op_e   opcode;
  reg_t        s;
  reg_t        t;
  imm_t        imm;
  bit_mode_e   bit_mode;
  reg_t        eflags_as_src;
  reg_t        d;
  reg_t        eflags;
  int          error_count;
  int          check_count;
  int          applied;
  logic [31:0] seed;

  tb_clock clock_gen (.clk(clk));

  alu DUT (
    .opcode        (opcode),
    .s             (s),
    .t             (t),
    .imm           (imm),
    .bit_mode      (bit_mode),
    .eflags_as_src (eflags_as_src),
    .d             (d),
    .eflags        (eflags)
  );

  alu_checker check_unit (
    .clk           (clk),
    .reset         (reset),
    .opcode        (opcode),
    .s             (s),
    .t             (t),
    .imm           (imm),
    .bit_mode      (bit_mode),
    .eflags_as_src (eflags_as_src),
    .d             (d),
    .eflags        (eflags),
    .error_count   (error_count),
    .check_count   (check_count)
  );

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] value);
    seed = xorshift(seed);
    value = seed;
  endtask

  task automatic apply(input micro_op_e op, input reg_t a, input reg_t b, input imm_t i,
                       input bit_mode_e m, input reg_t f);
    @(negedge clk);
    opcode = op;
    s = a;
    t = b;
    imm = i;
    bit_mode = m;
    eflags_as_src = f;
    applied++;
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("Simulation time limit reached before the run ended");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [5:0]  code;
    int          waited;
    reset = 1'b1;
    opcode = MICRO_MOV;
    s = '0;
    t = '0;
    imm = '0;
    bit_mode = MODE_64;
    eflags_as_src = '0;
    applied = 0;
    seed = 32'h0dc44eed;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    apply(MICRO_ADD, 64'hff, 64'h1, 32'h0, MODE_8, SRC_FLAGS); // Carry out and zero
    apply(MICRO_ADD, 64'h7f, 64'h1, 32'h0, MODE_8, SRC_FLAGS);
    apply(MICRO_ADDI, 64'hdead_beef_0000_ffff, 64'h0, 32'h1, MODE_16, SRC_FLAGS);
    apply(MICRO_ADC, 64'hffff_ffff, 64'h0, 32'h0, MODE_32, SRC_FLAGS);
    apply(MICRO_ADCI, '1, 64'h0, 32'h0, MODE_64, SRC_FLAGS);
    apply(MICRO_ADD, 64'h7fff_ffff_ffff_ffff, 64'h1, 32'h0, MODE_64, 64'h0);
    apply(MICRO_SUB, 64'h0, 64'h1, 32'h0, MODE_8, SRC_FLAGS); // Borrow
    apply(MICRO_SUB, 64'h8000, 64'h1, 32'h0, MODE_16, SRC_FLAGS);
    apply(MICRO_SUBI, 64'h5, 64'h0, 32'h5, MODE_32, SRC_FLAGS);
    apply(MICRO_SBB, 64'h0, 64'h0, 32'h0, MODE_64, SRC_FLAGS);
    apply(MICRO_SBBI, 64'h80, 64'h0, 32'h7f, MODE_8, SRC_FLAGS);
    apply(MICRO_CMP, 64'h1234, 64'h1234, 32'h0, MODE_64, SRC_FLAGS);
    apply(MICRO_CMPI, 64'h0001_0000, 64'h0, 32'h1, MODE_16, SRC_FLAGS);
    apply(MICRO_AND, 64'hf0f0, 64'h0ff0, 32'h0, MODE_8, SRC_FLAGS);
    apply(MICRO_ORI, 64'h8000_0000_0000_0000, 64'h0, 32'h3, MODE_64, SRC_FLAGS);
    apply(MICRO_XOR, 64'h55aa, 64'h55aa, 32'h0, MODE_16, SRC_FLAGS);
    apply(MICRO_TEST, 64'h00f0, 64'h000f, 32'h0, MODE_64, SRC_FLAGS);
    apply(MICRO_TESTI, 64'h80, 64'h0, 32'hff, MODE_8, SRC_FLAGS);
    apply(MICRO_SLLI, 64'h81, 64'h0, 32'd3, MODE_8, SRC_FLAGS);
    apply(MICRO_SLLI, 64'h81, 64'h0, 32'd8, MODE_8, SRC_FLAGS); // Count at the width
    apply(MICRO_SLLI, 64'h1, 64'h0, 32'd31, MODE_32, SRC_FLAGS);
    apply(MICRO_SLLI, 64'h1, 64'h0, 32'hffff_ffff, MODE_64, SRC_FLAGS);
    apply(MICRO_MOV, 64'h0, 64'hfedc_ba98_7654_3210, 32'h0, MODE_16, SRC_FLAGS);
    apply(MICRO_MOVI, 64'h0, 64'h0, 32'h8765_4321, MODE_64, SRC_FLAGS);
    apply(micro_op_e'(6'd0), 64'h1, 64'h2, 32'h3, MODE_64, SRC_FLAGS);
    apply(micro_op_e'(6'd22), 64'h1, 64'h2, 32'h3, MODE_32, SRC_FLAGS);
    apply(micro_op_e'(6'd63), 64'h1, 64'h2, 32'h3, MODE_8, SRC_FLAGS);

    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      draw(r0);
      draw(r1);
      draw(r2);
      draw(r3);
      draw(r4);
      code = 6'(r0 % 24); // Codes 0, 22 and 23 are undefined
      apply(micro_op_e'(code), {r1, r2}, {r2 ^ r3, r4}, (code == 6'd21) ? r3 % 80 : r3,
            bit_mode_e'(r4[1:0]), {r0, r1});
    end

    waited = 0;
    while (check_count <= applied && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (check_count <= applied) begin
      $display("Checker did not compare the last vector in time");
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > applied) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int PERIOD = 40;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire
